// ==== include/debug_macros.svh ====
// Debug module sizes and addresses

`ifndef DEBUG_MACROS_SVH
`define DEBUG_MACROS_SVH

// ----------------------------------------
// DMI widths
// ----------------------------------------
`define DMI_ADDR_W 7
`define DMI_DATA_W 32

// request queue entries, power of two
`define DMI_QUEUE_DEPTH 4

// ----------------------------------------
// debug register addresses
// ----------------------------------------
`define DM_DATA0      7'h04
`define DM_DATA1      7'h05
`define DM_DMCONTROL  7'h10
`define DM_DMSTATUS   7'h11
`define DM_ABSTRACTCS 7'h16
`define DM_COMMAND    7'h17
`define DM_HALTSUM0   7'h40

`endif

// ==== hdl/debugPkg.sv ====
// Debug module types

`include "debug_macros.svh"

package debugPkg;

   // ----------------------------------------
   // DMI request and response
   // ----------------------------------------

   // op field as sent by the transport
   typedef enum logic [1:0] {
      NOP   = 2'd0,
      READ  = 2'd1,
      WRITE = 2'd2
   } dmiOpT;

   // one request word, 41 bits
   typedef struct packed {
      dmiOpT                  op;
      logic [`DMI_ADDR_W-1:0] addr;
      logic [`DMI_DATA_W-1:0] data;
   } dmiReqT;

   // response status
   typedef enum logic [1:0] {
      OK     = 2'd0,
      FAILED = 2'd3
   } dmiStatusT;

   // ----------------------------------------
   // abstract command word
   // ----------------------------------------

   // access register layout, cmdtype 0
   typedef struct packed {
      logic [7:0]  cmdtype;
      logic        reserved;
      logic [2:0]  aarsize;
      logic        postincrement;
      logic        postexec;
      logic        transfer;
      logic        write;
      logic [15:0] regno;
   } accessRegT;

   // quick access layout, cmdtype 1
   typedef struct packed {
      logic [7:0]  cmdtype;
      logic [23:0] reserved;
   } quickAccessT;

   typedef union packed {
      accessRegT   ar;
      quickAccessT qa;
   } abstractCmdU;

   // hart run control
   typedef enum logic [1:0] {
      RUNNING  = 2'd0,
      HALTING  = 2'd1,
      HALTED   = 2'd2,
      RESUMING = 2'd3
   } haltStateT;

endpackage

// ==== hdl/dmiIf.sv ====
// Queued DMI request channel

interface dmiIf;

   // handshake
   logic valid;
   logic ready;

   // payload, held while valid and not ready
   debugPkg::dmiReqT req;

   // producer side
   modport src (
      output valid,
      output req,
      input  ready
   );

   // consumer side
   modport snk (
      input  valid,
      input  req,
      output ready
   );

endinterface

// ==== hdl/dmiIngress.sv ====
// DMI request ingress register

`include "debug_macros.svh"

module dmiIngress (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   reqValid,
   output logic                   reqReady,
   input  debugPkg::dmiOpT        reqOp,
   input  logic [`DMI_ADDR_W-1:0] reqAddr,
   input  logic [`DMI_DATA_W-1:0] reqData,
   dmiIf.src                      reqOut
);

   logic keep;

   // entry empty or being taken this cycle
   assign reqReady = ~reqOut.valid | reqOut.ready;

   // nop gets accepted but goes nowhere
   assign keep = reqValid & (reqOp != debugPkg::NOP);

   // ----------------------------------------
   // one entry holding register
   // ----------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         reqOut.valid <= 1'b0;
      end else if (reqReady) begin
         reqOut.valid <= keep;
      end
   end

   // payload only loads on a kept request
   always_ff @(posedge clk) begin
      if (reqReady & keep) begin
         reqOut.req.op   <= reqOp;
         reqOut.req.addr <= reqAddr;
         reqOut.req.data <= reqData;
      end
   end

endmodule

// ==== hdl/dmiReqQueue.sv ====
// DMI request FIFO

`include "debug_macros.svh"

module dmiReqQueue (
   input logic clk,
   input logic rst,
   dmiIf.snk   inPort,
   dmiIf.src   outPort
);

   localparam int depth = `DMI_QUEUE_DEPTH;
   localparam int ptrWidth = $clog2(depth);
   localparam logic [ptrWidth:0] fullCount = (ptrWidth + 1)'(depth);

   debugPkg::dmiReqT entries [depth];

   logic [ptrWidth-1:0] wrPtr;
   logic [ptrWidth-1:0] rdPtr;
   logic [ptrWidth:0]   count;
   logic                push;
   logic                pop;

   // ----------------------------------------
   // handshakes
   // ----------------------------------------
   assign inPort.ready  = (count != fullCount);
   assign outPort.valid = (count != '0);
   assign push = inPort.valid & inPort.ready;
   assign pop  = outPort.valid & outPort.ready;

   // head entry straight from storage
   assign outPort.req = entries[rdPtr];

   // storage, no reset
   always_ff @(posedge clk) begin
      if (push) begin
         entries[wrPtr] <= inPort.req;
      end
   end

   // ----------------------------------------
   // pointers and fill count
   // ----------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         wrPtr <= '0;
         rdPtr <= '0;
         count <= '0;
      end else begin
         // pointers wrap on their own width
         if (push) begin
            wrPtr <= wrPtr + 1'b1;
         end
         if (pop) begin
            rdPtr <= rdPtr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

// ==== hdl/haltControl.sv ====
// Hart halt and resume FSM

module haltControl (
   input  logic                clk,
   input  logic                rst,
   input  logic                haltReq,
   input  logic                resumeReq,
   input  logic                debugMode,
   output debugPkg::haltStateT state,
   output logic                resumeAck
);

   debugPkg::haltStateT stateNext;

   // ----------------------------------------
   // next state
   // ----------------------------------------
   always_comb begin
      stateNext = state;
      case (state)
         debugPkg::RUNNING: begin
            if (haltReq) stateNext = debugPkg::HALTING;
         end
         // wait for the hart to enter debug mode
         debugPkg::HALTING: begin
            if (debugMode) stateNext = debugPkg::HALTED;
         end
         debugPkg::HALTED: begin
            if (resumeReq) stateNext = debugPkg::RESUMING;
         end
         // wait for the hart to leave debug mode
         debugPkg::RESUMING: begin
            if (!debugMode) stateNext = debugPkg::RUNNING;
         end
         default: stateNext = debugPkg::RUNNING;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state     <= debugPkg::RUNNING;
         resumeAck <= 1'b0;
      end else begin
         state <= stateNext;
         // ack on arrival in running from resuming
         if (state == debugPkg::RESUMING && stateNext == debugPkg::RUNNING) begin
            resumeAck <= 1'b1;
         end else if (state == debugPkg::HALTED && stateNext == debugPkg::RESUMING) begin
            // new resume drops the old ack
            resumeAck <= 1'b0;
         end
      end
   end

endmodule

// ==== hdl/abstractCmd.sv ====
// Access register command executor

`include "debug_macros.svh"

module abstractCmd (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   start,
   input  debugPkg::abstractCmdU  cmd,
   input  logic                   halted,
   input  logic [`DMI_DATA_W-1:0] data0,
   output logic                   busy,
   output logic                   done,
   output logic [2:0]             err,
   output logic                   capture,
   output logic [`DMI_DATA_W-1:0] captureData,
   output logic [4:0]             regAddr,
   output logic [`DMI_DATA_W-1:0] regWData,
   output logic                   regWrite,
   input  logic [`DMI_DATA_W-1:0] regRData
);

   debugPkg::abstractCmdU cmdReg;

   logic       classified;
   logic       executing;
   logic       doTransfer;
   logic [2:0] errNext;

   // ----------------------------------------
   // error classification, first hit wins
   // ----------------------------------------
   always_comb begin
      if (cmd.qa.cmdtype != 8'd0) begin
         errNext = 3'd2;                  // quick access and others unsupported
      end else if (cmd.ar.aarsize != 3'd2) begin
         errNext = 3'd2;                  // 32 bit only
      end else if (!halted) begin
         errNext = 3'd4;
      end else if (cmd.ar.transfer && cmd.ar.regno[15:5] != 11'h080) begin
         errNext = 3'd3;                  // gprs live at 0x1000..0x101f
      end else begin
         errNext = 3'd0;
      end
   end

   // two stage sequence, classify then execute
   always_ff @(posedge clk) begin
      if (rst) begin
         classified <= 1'b0;
         executing  <= 1'b0;
      end else begin
         classified <= start;
         executing  <= classified;
      end
   end

   always_ff @(posedge clk) begin
      if (start) begin
         cmdReg <= cmd;
         err    <= errNext;
      end
   end

   assign busy = classified | executing;
   assign done = executing;

   // ----------------------------------------
   // execute stage
   // ----------------------------------------
   assign doTransfer = executing & (err == 3'd0) & cmdReg.ar.transfer;
   assign regWrite = doTransfer & cmdReg.ar.write;
   assign capture  = doTransfer & ~cmdReg.ar.write;

   // hart read port is combinational on regAddr
   assign regAddr     = cmdReg.ar.regno[4:0];
   assign regWData    = data0;
   assign captureData = regRData;

endmodule

// ==== hdl/debugModuleCore.sv ====
// Debug module register core

`include "debug_macros.svh"

module debugModuleCore (
   input  logic                   clk,
   input  logic                   rst,
   dmiIf.snk                      reqIn,
   output logic                   rspValid,
   input  logic                   rspReady,
   output logic [`DMI_DATA_W-1:0] rspData,
   output debugPkg::dmiStatusT    rspStatus,
   output logic                   haltReq,
   output logic                   resumeReq,
   output logic                   ndmReset,
   input  logic                   debugMode,
   output logic [4:0]             regAddr,
   output logic [`DMI_DATA_W-1:0] regWData,
   output logic                   regWrite,
   input  logic [`DMI_DATA_W-1:0] regRData
);

   debugPkg::haltStateT haltState;

   logic [`DMI_DATA_W-1:0] data0;
   logic [`DMI_DATA_W-1:0] data1;
   logic [`DMI_DATA_W-1:0] readData;
   logic [`DMI_DATA_W-1:0] dmStatus;
   logic [`DMI_DATA_W-1:0] captureData;
   logic [2:0]             cmderr;
   logic [2:0]             cmdErr;
   logic                   dmActive;
   logic                   resumeAck;
   logic                   halted;
   logic                   running;
   logic                   cmdBusy;
   logic                   cmdDone;
   logic                   capture;
   logic                   take;
   logic                   isWrite;
   logic                   cmdWrite;
   logic                   cmdStart;
   logic                   cmdReject;

   // ----------------------------------------
   // request decode
   // ----------------------------------------
   // serial, one request in flight at a time
   assign reqIn.ready = ~rspValid & ~cmdBusy;
   assign take      = reqIn.valid & reqIn.ready;
   assign isWrite   = (reqIn.req.op == debugPkg::WRITE);
   assign cmdWrite  = take & isWrite & (reqIn.req.addr == `DM_COMMAND);
   assign cmdStart  = cmdWrite & ~cmdBusy & (cmderr == 3'd0);
   assign cmdReject = cmdWrite & cmdBusy;

   assign halted  = (haltState == debugPkg::HALTED);
   assign running = (haltState == debugPkg::RUNNING);

   // status summaries, single hart so all equals any
   always_comb begin
      dmStatus        = '0;
      dmStatus[17:16] = {2{resumeAck}};
      dmStatus[11:10] = {2{running}};
      dmStatus[9:8]   = {2{halted}};
      dmStatus[3:0]   = 4'd3;
   end

   // read mux, unknown addresses give zero
   always_comb begin
      case (reqIn.req.addr)
         `DM_DATA0:      readData = data0;
         `DM_DATA1:      readData = data1;
         // resumereq always reads back 0
         `DM_DMCONTROL:  readData = {haltReq, 29'd0, ndmReset, dmActive};
         `DM_DMSTATUS:   readData = dmStatus;
         `DM_ABSTRACTCS: readData = {19'd0, cmdBusy, 1'b0, cmderr, 4'd0, 4'd2};
         `DM_HALTSUM0:   readData = {31'd0, halted};
         default:        readData = '0;
      endcase
   end

   // ----------------------------------------
   // debug registers
   // ----------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         data0     <= '0;
         data1     <= '0;
         haltReq   <= 1'b0;
         resumeReq <= 1'b0;
         ndmReset  <= 1'b0;
         dmActive  <= 1'b0;
         cmderr    <= 3'd0;
      end else begin
         if (take && isWrite) begin
            case (reqIn.req.addr)
               `DM_DATA0: data0 <= reqIn.req.data;
               `DM_DATA1: data1 <= reqIn.req.data;
               `DM_DMCONTROL: begin
                  haltReq   <= reqIn.req.data[31];
                  resumeReq <= reqIn.req.data[30];
                  ndmReset  <= reqIn.req.data[1];
                  dmActive  <= reqIn.req.data[0];
               end
               // cmderr is write one to clear
               `DM_ABSTRACTCS: begin
                  if (|reqIn.req.data[10:8]) cmderr <= 3'd0;
               end
               default: ;
            endcase
         end
         // resumereq drops once the hart is back and acked
         if (resumeReq && resumeAck && running && !(take && isWrite)) begin
            resumeReq <= 1'b0;
         end
         if (capture) begin
            data0 <= captureData;
         end
         if (cmdReject) begin
            cmderr <= 3'd1;
         end else if (cmdDone && cmdErr != 3'd0) begin
            cmderr <= cmdErr;
         end
      end
   end

   // ----------------------------------------
   // response register
   // ----------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         rspValid <= 1'b0;
      end else if ((take && !cmdStart) || cmdDone) begin
         rspValid <= 1'b1;
      end else if (rspReady) begin
         rspValid <= 1'b0;
      end
   end

   // held until taken, core stalls meanwhile
   always_ff @(posedge clk) begin
      if (take && !cmdStart) begin
         rspData   <= (reqIn.req.op == debugPkg::READ) ? readData : '0;
         rspStatus <= cmdReject ? debugPkg::FAILED : debugPkg::OK;
      end else if (cmdDone) begin
         rspData   <= '0;
         rspStatus <= debugPkg::OK;
      end
   end

   haltControl haltCtl (
      .clk       (clk),
      .rst       (rst),
      .haltReq   (haltReq),
      .resumeReq (resumeReq),
      .debugMode (debugMode),
      .state     (haltState),
      .resumeAck (resumeAck)
   );

   abstractCmd cmdExec (
      .clk         (clk),
      .rst         (rst),
      .start       (cmdStart),
      .cmd         (reqIn.req.data),
      .halted      (halted),
      .data0       (data0),
      .busy        (cmdBusy),
      .done        (cmdDone),
      .err         (cmdErr),
      .capture     (capture),
      .captureData (captureData),
      .regAddr     (regAddr),
      .regWData    (regWData),
      .regWrite    (regWrite),
      .regRData    (regRData)
   );

endmodule

// ==== hdl/dmTop.sv ====
// Debug module top level

`include "debug_macros.svh"

module dmTop (
   input  logic                   clk,
   input  logic                   rst,
   // DMI request
   input  logic                   reqValid,
   output logic                   reqReady,
   input  debugPkg::dmiOpT        reqOp,
   input  logic [`DMI_ADDR_W-1:0] reqAddr,
   input  logic [`DMI_DATA_W-1:0] reqData,
   // DMI response
   output logic                   rspValid,
   input  logic                   rspReady,
   output logic [`DMI_DATA_W-1:0] rspData,
   output debugPkg::dmiStatusT    rspStatus,
   // hart control
   output logic                   haltReq,
   output logic                   resumeReq,
   output logic                   ndmReset,
   input  logic                   debugMode,
   // hart register file port
   output logic [4:0]             regAddr,
   output logic [`DMI_DATA_W-1:0] regWData,
   output logic                   regWrite,
   input  logic [`DMI_DATA_W-1:0] regRData
);

   // ----------------------------------------
   // internal request channels
   // ----------------------------------------
   dmiIf ingressToQueue ();
   dmiIf queueToCore ();

   dmiIngress ingress (
      .clk      (clk),
      .rst      (rst),
      .reqValid (reqValid),
      .reqReady (reqReady),
      .reqOp    (reqOp),
      .reqAddr  (reqAddr),
      .reqData  (reqData),
      .reqOut   (ingressToQueue)
   );

   dmiReqQueue reqQueue (
      .clk     (clk),
      .rst     (rst),
      .inPort  (ingressToQueue),
      .outPort (queueToCore)
   );

   debugModuleCore core (
      .clk       (clk),
      .rst       (rst),
      .reqIn     (queueToCore),
      .rspValid  (rspValid),
      .rspReady  (rspReady),
      .rspData   (rspData),
      .rspStatus (rspStatus),
      .haltReq   (haltReq),
      .resumeReq (resumeReq),
      .ndmReset  (ndmReset),
      .debugMode (debugMode),
      .regAddr   (regAddr),
      .regWData  (regWData),
      .regWrite  (regWrite),
      .regRData  (regRData)
   );

endmodule

// ==== tests/hartModel.sv ====
// Behavioral hart model

module hartModel (
   input  logic        clk,
   input  logic        rst,
   input  logic        haltReq,
   input  logic        resumeReq,
   output logic        debugMode,
   input  logic [4:0]  regAddr,
   input  logic [31:0] regWData,
   input  logic        regWrite,
   output logic [31:0] regRData
);

   timeunit 1ns;
   timeprecision 100ps;

   logic [31:0] regs [32];
   logic [1:0]  delay;

   // x0 is hardwired to zero
   assign regRData = (regAddr == 5'd0) ? 32'd0 : regs[regAddr];

   // ----------------------------------------
   // register file, reset to index * 0x11
   // ----------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= 32'(i * 32'h11);
         end
      end else if (regWrite && regAddr != 5'd0) begin
         regs[regAddr] <= regWData;
      end
   end

   // debug mode toggles on the third cycle of a held request
   always_ff @(posedge clk) begin
      if (rst) begin
         debugMode <= 1'b0;
         delay     <= 2'd0;
      end else if (debugMode ? resumeReq : haltReq) begin
         if (delay == 2'd2) begin
            debugMode <= ~debugMode;
            delay     <= 2'd0;
         end else begin
            delay <= delay + 2'd1;
         end
      end else begin
         delay <= 2'd0;
      end
   end

endmodule

// ==== tests/dmTb.sv ====
// Debug module testbench

`include "debug_macros.svh"

module dmTb;

   timeunit 1ns;
   timeprecision 100ps;

   // one table row
   typedef struct packed {
      debugPkg::dmiOpT        op;
      logic [`DMI_ADDR_W-1:0] addr;
      logic [`DMI_DATA_W-1:0] data;
      logic [`DMI_DATA_W-1:0] expData;
      logic [`DMI_DATA_W-1:0] mask;
      debugPkg::dmiStatusT    expStatus;
      logic                   poll;
   } rowT;

   // access register command words
   localparam logic [31:0] cmdRead7   = 32'h0022_1007;
   localparam logic [31:0] cmdWrite5  = 32'h0023_1005;
   localparam logic [31:0] cmdQuick   = 32'h0100_0000;
   localparam logic [31:0] cmdBadReg  = 32'h0022_2000;
   localparam logic [31:0] cmdBadSize = 32'h0032_1007;
   localparam int          burstLen   = 6;

   logic                   clk;
   logic                   rst;
   logic                   reqValid;
   logic                   reqReady;
   debugPkg::dmiOpT        reqOp;
   logic [`DMI_ADDR_W-1:0] reqAddr;
   logic [`DMI_DATA_W-1:0] reqData;
   logic                   rspValid;
   logic                   rspReady;
   logic [`DMI_DATA_W-1:0] rspData;
   debugPkg::dmiStatusT    rspStatus;
   logic                   haltReq;
   logic                   resumeReq;
   logic                   ndmReset;
   logic                   debugMode;
   logic [4:0]             regAddr;
   logic [`DMI_DATA_W-1:0] regWData;
   logic                   regWrite;
   logic [`DMI_DATA_W-1:0] regRData;

   rowT                    rows [$];
   logic [`DMI_DATA_W-1:0] rspDataQ [$];
   debugPkg::dmiStatusT    rspStatusQ [$];
   logic [`DMI_DATA_W-1:0] rnd [6];
   logic [`DMI_ADDR_W-1:0] burstAddr [burstLen];
   logic [`DMI_DATA_W-1:0] burstExp [burstLen];
   logic [`DMI_DATA_W-1:0] burstGot;
   debugPkg::dmiStatusT    burstStatus;
   integer                 seed;
   int                     sentCount;
   int                     rspTotal;
   int                     dataErrors;
   int                     statusErrors;
   int                     hartErrors;
   int                     otherErrors;
   longint                 watchLimit;
   bit                     tableBuilt;
   bit                     sawStall;

   dmTop dut (
      .clk       (clk),
      .rst       (rst),
      .reqValid  (reqValid),
      .reqReady  (reqReady),
      .reqOp     (reqOp),
      .reqAddr   (reqAddr),
      .reqData   (reqData),
      .rspValid  (rspValid),
      .rspReady  (rspReady),
      .rspData   (rspData),
      .rspStatus (rspStatus),
      .haltReq   (haltReq),
      .resumeReq (resumeReq),
      .ndmReset  (ndmReset),
      .debugMode (debugMode),
      .regAddr   (regAddr),
      .regWData  (regWData),
      .regWrite  (regWrite),
      .regRData  (regRData)
   );

   hartModel hart (
      .clk       (clk),
      .rst       (rst),
      .haltReq   (haltReq),
      .resumeReq (resumeReq),
      .debugMode (debugMode),
      .regAddr   (regAddr),
      .regWData  (regWData),
      .regWrite  (regWrite),
      .regRData  (regRData)
   );

   // 100 ns period
   always #50 clk = ~clk;

   // collect every response at the falling edge, transfer lands on the next rise
   always @(negedge clk) begin
      if (!rst && rspValid && rspReady) begin
         rspDataQ.push_back(rspData);
         rspStatusQ.push_back(rspStatus);
         rspTotal++;
      end
   end

   // ----------------------------------------
   // compare tasks
   // ----------------------------------------
   task automatic checkData(input string name, input logic [`DMI_DATA_W-1:0] exp,
                            input logic [`DMI_DATA_W-1:0] act);
      if (act !== exp) begin
         $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
         dataErrors++;
      end
   endtask

   task automatic checkStatus(input debugPkg::dmiStatusT exp, input debugPkg::dmiStatusT act);
      if (act !== exp) begin
         $display("[FAIL] %0t rspStatus expected %s got %s", $time, exp.name(), act.name());
         statusErrors++;
      end
   endtask

   task automatic checkHart(input int idx, input logic [`DMI_DATA_W-1:0] exp);
      if (hart.regs[idx] !== exp) begin
         $display("[FAIL] %0t hart.regs[%0d] expected %h got %h",
                  $time, idx, exp, hart.regs[idx]);
         hartErrors++;
      end
   endtask

   // abstractcs from cmderr, datacount 2, not busy
   function automatic logic [31:0] abstractcsWord(input logic [2:0] err);
      return (32'(err) << 8) | 32'd2;
   endfunction

   // ----------------------------------------
   // table rows
   // ----------------------------------------
   task automatic addRow(input debugPkg::dmiOpT op, input logic [6:0] addr,
                         input logic [31:0] data, input logic [31:0] expData,
                         input logic [31:0] mask, input logic poll);
      rowT row;
      row.op        = op;
      row.addr      = addr;
      row.data      = data;
      row.expData   = expData;
      row.mask      = mask;
      row.expStatus = debugPkg::OK;
      row.poll      = poll;
      rows.push_back(row);
   endtask

   // write response data is a don't care
   task automatic writeRow(input logic [6:0] addr, input logic [31:0] data);
      addRow(debugPkg::WRITE, addr, data, '0, '0, 1'b0);
   endtask

   task automatic readRow(input logic [6:0] addr, input logic [31:0] exp);
      addRow(debugPkg::READ, addr, '0, exp, '1, 1'b0);
   endtask

   task automatic pollRow(input logic [6:0] addr, input logic [31:0] mask,
                          input logic [31:0] exp);
      addRow(debugPkg::READ, addr, '0, exp, mask, 1'b1);
   endtask

   task automatic nopRow(input logic [6:0] addr);
      addRow(debugPkg::NOP, addr, '1, '0, '0, 1'b0);
   endtask

   task automatic buildTable();
      // plain registers, nops and holes
      writeRow(`DM_DATA0, rnd[0]);
      writeRow(`DM_DATA1, rnd[1]);
      readRow(`DM_DATA0, rnd[0]);
      readRow(`DM_DATA1, rnd[1]);
      nopRow(`DM_DATA0);
      readRow(7'h20, '0);
      nopRow(`DM_COMMAND);
      readRow(7'h7f, '0);
      readRow(`DM_ABSTRACTCS, abstractcsWord(3'd0));
      readRow(`DM_DMSTATUS, 32'h0000_0c03);
      // ndmreset on and off
      writeRow(`DM_DMCONTROL, 32'h0000_0003);
      readRow(`DM_DMCONTROL, 32'h0000_0003);
      writeRow(`DM_DMCONTROL, 32'h0000_0001);
      // command while running
      writeRow(`DM_COMMAND, cmdRead7);
      readRow(`DM_ABSTRACTCS, abstractcsWord(3'd4));
      writeRow(`DM_ABSTRACTCS, 32'h0000_0100);
      readRow(`DM_ABSTRACTCS, abstractcsWord(3'd0));
      // halt the hart
      writeRow(`DM_DMCONTROL, 32'h8000_0001);
      readRow(`DM_DMCONTROL, 32'h8000_0001);
      pollRow(`DM_DMSTATUS, 32'h0000_0300, 32'h0000_0300);
      readRow(`DM_HALTSUM0, 32'h1);
      // gpr write from data0, then gpr read into data0
      writeRow(`DM_DATA0, rnd[2]);
      writeRow(`DM_COMMAND, cmdWrite5);
      readRow(`DM_ABSTRACTCS, abstractcsWord(3'd0));
      writeRow(`DM_COMMAND, cmdRead7);
      readRow(`DM_DATA0, 32'h77);
      readRow(`DM_ABSTRACTCS, abstractcsWord(3'd0));
      // quick access, then a valid command is ignored
      writeRow(`DM_COMMAND, cmdQuick);
      readRow(`DM_ABSTRACTCS, abstractcsWord(3'd2));
      writeRow(`DM_DATA0, rnd[3]);
      writeRow(`DM_COMMAND, cmdRead7);
      readRow(`DM_DATA0, rnd[3]);
      readRow(`DM_ABSTRACTCS, abstractcsWord(3'd2));
      writeRow(`DM_ABSTRACTCS, 32'h0000_0100);
      readRow(`DM_ABSTRACTCS, abstractcsWord(3'd0));
      // regno out of range
      writeRow(`DM_COMMAND, cmdBadReg);
      readRow(`DM_ABSTRACTCS, abstractcsWord(3'd3));
      writeRow(`DM_ABSTRACTCS, 32'h0000_0100);
      // 64 bit access
      writeRow(`DM_COMMAND, cmdBadSize);
      readRow(`DM_ABSTRACTCS, abstractcsWord(3'd2));
      writeRow(`DM_ABSTRACTCS, 32'h0000_0100);
      readRow(`DM_ABSTRACTCS, abstractcsWord(3'd0));
      // resume, haltreq dropped at the same time
      writeRow(`DM_DMCONTROL, 32'h4000_0001);
      pollRow(`DM_DMSTATUS, 32'h0003_0c00, 32'h0003_0c00);
      readRow(`DM_DMCONTROL, 32'h0000_0001);
      // fresh words for the burst
      writeRow(`DM_DATA0, rnd[4]);
      writeRow(`DM_DATA1, rnd[5]);
   endtask

   // ----------------------------------------
   // bus tasks
   // ----------------------------------------
   task automatic sendReq(input debugPkg::dmiOpT op, input logic [6:0] addr,
                          input logic [31:0] data);
      @(posedge clk);
      reqValid <= 1'b1;
      reqOp    <= op;
      reqAddr  <= addr;
      reqData  <= data;
      // ready is stable at the falling edge
      @(negedge clk);
      while (!reqReady) begin
         @(negedge clk);
      end
      @(posedge clk);
      reqValid <= 1'b0;
      if (op != debugPkg::NOP) begin
         sentCount++;
      end
   endtask

   task automatic takeRsp(output logic [31:0] data, output debugPkg::dmiStatusT status);
      while (rspDataQ.size() == 0) begin
         @(posedge clk);
      end
      data   = rspDataQ.pop_front();
      status = rspStatusQ.pop_front();
   endtask

   task automatic applyRow(input rowT row);
      logic [31:0]         got;
      debugPkg::dmiStatusT status;
      int                  tries;
      tries = 0;
      if (row.poll) begin
         // re-read until the masked bits match
         do begin
            sendReq(debugPkg::READ, row.addr, '0);
            takeRsp(got, status);
            tries++;
         end while ((got & row.mask) != row.expData && tries < 40);
         if ((got & row.mask) != row.expData) begin
            $display("address %h never reached %h under mask %h after 40 reads",
                     row.addr, row.expData, row.mask);
            otherErrors++;
         end
         checkStatus(row.expStatus, status);
      end else begin
         sendReq(row.op, row.addr, row.data);
         if (row.op != debugPkg::NOP) begin
            takeRsp(got, status);
            checkStatus(row.expStatus, status);
            if (row.op == debugPkg::READ) begin
               checkData("rspData", row.expData, got & row.mask);
            end
            // ndmreset pin follows dmcontrol bit 1
            if (row.op == debugPkg::WRITE && row.addr == `DM_DMCONTROL) begin
               checkData("ndmReset", 32'(row.data[1]), 32'(ndmReset));
            end
         end
      end
   endtask

   // ----------------------------------------
   // watchdog
   // ----------------------------------------
   initial begin
      wait (tableBuilt);
      #(watchLimit);
      $display("watchdog ran out after %0d ns with responses still outstanding", watchLimit);
      $display("SIMULATION FAILED");
      $finish;
   end

   // ----------------------------------------
   // main sequence
   // ----------------------------------------
   initial begin
      clk      = 1'b0;
      rst      = 1'b1;
      reqValid = 1'b0;
      reqOp    = debugPkg::NOP;
      reqAddr  = '0;
      reqData  = '0;
      rspReady = 1'b1;
      seed     = 44;
      for (int k = 0; k < 6; k++) begin
         rnd[k] = $random(seed);
      end
      buildTable();
      // burst reads and what they return
      burstAddr = '{`DM_DATA0, `DM_DATA1, `DM_DMSTATUS, `DM_HALTSUM0,
                    `DM_ABSTRACTCS, `DM_DMCONTROL};
      burstExp  = '{rnd[4], rnd[5], 32'h0003_0c03, 32'h0, abstractcsWord(3'd0), 32'h1};
      // rows plus burst plus reset, 60 cycles each
      watchLimit = longint'(rows.size() + burstLen + 10) * 60 * 100;
      tableBuilt = 1'b1;

      repeat (10) @(posedge clk);
      rst <= 1'b0;

      foreach (rows[i]) begin
         applyRow(rows[i]);
      end

      // back-pressure burst, responses held 20 cycles
      @(posedge clk);
      rspReady <= 1'b0;
      fork
         begin
            for (int i = 0; i < burstLen; i++) begin
               sendReq(debugPkg::READ, burstAddr[i], '0);
            end
         end
         begin
            repeat (20) begin
               @(negedge clk);
               if (!reqReady) sawStall = 1'b1;
            end
            @(posedge clk);
            rspReady <= 1'b1;
         end
      join
      if (!sawStall) begin
         $display("reqReady never dropped while responses were held");
         otherErrors++;
      end
      for (int i = 0; i < burstLen; i++) begin
         takeRsp(burstGot, burstStatus);
         checkStatus(debugPkg::OK, burstStatus);
         checkData("rspData", burstExp[i], burstGot);
      end

      // hart register 5 got data0 through the command
      checkHart(5, rnd[2]);
      repeat (5) @(posedge clk);
      if (rspTotal != sentCount || rspDataQ.size() != 0) begin
         $display("got %0d responses for %0d read and write requests", rspTotal, sentCount);
         otherErrors++;
      end

      $display("errors: data %0d, status %0d, hart %0d, other %0d",
               dataErrors, statusErrors, hartErrors, otherErrors);
      if (dataErrors + statusErrors + hartErrors + otherErrors == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

// ==== compile.f ====
+incdir+include
hdl/debugPkg.sv
hdl/dmiIf.sv
hdl/dmiIngress.sv
hdl/dmiReqQueue.sv
hdl/haltControl.sv
hdl/abstractCmd.sv
hdl/debugModuleCore.sv
hdl/dmTop.sv
tests/hartModel.sv
tests/dmTb.sv
